// ==== hw/bp_config_pkg.sv ====
/*
 * Table geometry for the branch predictor: BHT and BTB sizes,
 * PC bit fields used for indexing and tagging, and their typedefs
 */
package bp_config_pkg;

    // instructions are word aligned, bits 1:0 never index anything
    localparam int PC_ALIGN_BITS = 2;

    // branch history table, indexed by pc[9:2]
    localparam int BHT_INDEX_BITS = 8;
    localparam int BHT_ENTRIES = 1 << BHT_INDEX_BITS;      // 256 counters

    // branch target buffer, direct mapped
    localparam int BTB_INDEX_BITS = 6;                     // pc[7:2]
    localparam int BTB_ENTRIES = 1 << BTB_INDEX_BITS;      // 64 entries
    localparam int BTB_TAG_BITS = 24;                      // pc[31:8]

    typedef logic [BHT_INDEX_BITS-1:0] bht_index_t;
    typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
    typedef logic [BTB_TAG_BITS-1:0] btb_tag_t;

endpackage

// ==== hw/bp_types_pkg.sv ====
/*
 * Pipeline side types for the branch predictor:
 * PC width and type, sequential PC step, 2-bit counter states
 */
package bp_types_pkg;

    localparam int PC_WIDTH = 32;

    typedef logic [PC_WIDTH-1:0] pc_t;

    // distance to the next sequential instruction
    localparam pc_t PC_STEP = 32'd4;

    // saturating counter, top bit is the taken prediction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } counter_state_e;

endpackage

// ==== hw/bht.sv ====
/*
 * Branch history table: 2-bit saturating counters,
 * asynchronous lookup read and one synchronous update port
 */
`timescale 1ns/1ps

module bht
    import bp_config_pkg::*;
    import bp_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // fetch side lookup
    input  pc_t  lookup_pc,
    output logic counter_msb,

    // resolve side update
    input  logic update_valid,
    input  pc_t  update_pc,
    input  logic update_taken
);

    counter_state_e counters [BHT_ENTRIES];

    bht_index_t     lookup_idx;
    bht_index_t     update_idx;
    counter_state_e update_cur;
    counter_state_e update_next;

    assign lookup_idx = lookup_pc[PC_ALIGN_BITS +: BHT_INDEX_BITS];    // pc[9:2]
    assign update_idx = update_pc[PC_ALIGN_BITS +: BHT_INDEX_BITS];

    // read is combinational, so a same-cycle update is not visible yet
    assign counter_msb = counters[lookup_idx][1];

    assign update_cur = counters[update_idx];

    // one step toward the resolved direction, saturating at both ends
    always_comb begin
        update_next = update_cur;
        case (update_cur)
            strong_nt: begin
                update_next = update_taken ? weak_nt : strong_nt;
            end
            weak_nt: begin
                update_next = update_taken ? weak_t : strong_nt;
            end
            weak_t: begin
                update_next = update_taken ? strong_t : weak_nt;
            end
            strong_t: begin
                update_next = update_taken ? strong_t : weak_t;
            end
            default: begin
                update_next = strong_nt;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                counters[i] <= strong_nt;    // everything starts not taken
            end
        end else if (update_valid) begin
            counters[update_idx] <= update_next;
        end
    end

endmodule

// ==== hw/btb.sv ====
/*
 * Direct mapped branch target buffer with tags and valid bits,
 * combinational lookup and one update port for taken resolves
 */
`timescale 1ns/1ps

module btb
    import bp_config_pkg::*;
    import bp_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // fetch side lookup
    input  pc_t  lookup_pc,
    output logic hit,
    output pc_t  target,

    // resolve side update
    input  logic update_valid,
    input  pc_t  update_pc,
    input  logic update_taken,
    input  pc_t  update_target
);

    logic     valid_bits [BTB_ENTRIES];
    btb_tag_t tag_mem    [BTB_ENTRIES];
    pc_t      target_mem [BTB_ENTRIES];

    btb_index_t lookup_idx;
    btb_tag_t   lookup_tag;
    btb_index_t update_idx;
    btb_tag_t   update_tag;
    logic       write_en;

    // index is pc[7:2] and tag is pc[31:8]
    assign lookup_idx = lookup_pc[PC_ALIGN_BITS +: BTB_INDEX_BITS];
    assign lookup_tag = lookup_pc[PC_ALIGN_BITS + BTB_INDEX_BITS +: BTB_TAG_BITS];
    assign update_idx = update_pc[PC_ALIGN_BITS +: BTB_INDEX_BITS];
    assign update_tag = update_pc[PC_ALIGN_BITS + BTB_INDEX_BITS +: BTB_TAG_BITS];

    assign write_en = update_valid && update_taken;    // not-taken leaves entry alone

    assign hit    = valid_bits[lookup_idx] && (tag_mem[lookup_idx] == lookup_tag);
    assign target = target_mem[lookup_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_bits[i] <= 1'b0;
            end
        end else if (write_en) begin
            valid_bits[update_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            tag_mem[update_idx]    <= update_tag;
            target_mem[update_idx] <= update_target;
        end
    end

endmodule

// ==== hw/mispredict_check.sv ====
/*
 * Misprediction check for resolved branches: compares the next PC
 * predicted at fetch with the actual one, registers flag and redirect
 */
`timescale 1ns/1ps

module mispredict_check
    import bp_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // resolved branch, with the prediction carried from fetch
    input  logic resolve_valid,
    input  pc_t  resolve_pc,
    input  logic resolve_taken,
    input  pc_t  resolve_target,
    input  logic resolve_pred_taken,
    input  pc_t  resolve_pred_target,

    output logic mispredict,
    output pc_t  redirect_pc
);

    pc_t fall_through;
    pc_t actual_next;
    pc_t predicted_next;
    logic next_differs;

    assign fall_through = resolve_pc + PC_STEP;

    assign actual_next    = resolve_taken ? resolve_target : fall_through;
    assign predicted_next = resolve_pred_taken ? resolve_pred_target : fall_through;

    // a taken prediction to the right target is still correct
    assign next_differs = (actual_next != predicted_next);

    always_ff @(posedge clk) begin
        if (reset) begin
            mispredict  <= 1'b0;
            redirect_pc <= '0;
        end else if (resolve_valid) begin
            mispredict  <= next_differs;
            redirect_pc <= actual_next;    // fetch restarts here on a mispredict
        end else begin
            mispredict  <= 1'b0;           // pulse only for the cycle after a resolve
        end
    end

endmodule

// ==== hw/branch_predictor.sv ====
/*
 * Branch predictor top: BHT and BTB lookup into a prediction and
 * next fetch PC, resolve path to table updates and mispredict check
 */
`timescale 1ns/1ps

module branch_predictor
    import bp_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    input  pc_t  fetch_pc,

    input  logic resolve_valid,
    input  pc_t  resolve_pc,
    input  logic resolve_taken,
    input  pc_t  resolve_target,
    input  logic resolve_pred_taken,
    input  pc_t  resolve_pred_target,

    output logic pred_taken,
    output pc_t  pred_target,
    output logic btb_hit,
    output pc_t  next_fetch_pc,
    output logic mispredict,
    output pc_t  redirect_pc
);

    logic counter_msb;

    bht u_bht (
        .clk          (clk),
        .reset        (reset),
        .lookup_pc    (fetch_pc),
        .counter_msb  (counter_msb),
        .update_valid (resolve_valid),
        .update_pc    (resolve_pc),
        .update_taken (resolve_taken)
    );

    btb u_btb (
        .clk           (clk),
        .reset         (reset),
        .lookup_pc     (fetch_pc),
        .hit           (btb_hit),
        .target        (pred_target),
        .update_valid  (resolve_valid),
        .update_pc     (resolve_pc),
        .update_taken  (resolve_taken),
        .update_target (resolve_target)
    );

    // no known target means no taken prediction
    assign pred_taken    = btb_hit && counter_msb;
    assign next_fetch_pc = pred_taken ? pred_target : fetch_pc + PC_STEP;

    mispredict_check u_mispredict_check (
        .clk                 (clk),
        .reset               (reset),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .mispredict          (mispredict),
        .redirect_pc         (redirect_pc)
    );

endmodule

// ==== testbench/bp_checker.sv ====
/*
 * Checker for the branch predictor testbench: reference model of the
 * BHT, the BTB and the mispredict rule, per-test and total counts
 */
`timescale 1ns/1ps

module bp_checker
    import bp_types_pkg::*;
(
    input  logic clk,
    input  logic reset,

    // stimulus, as driven into the DUT
    input  pc_t  fetch_pc,
    input  logic resolve_valid,
    input  pc_t  resolve_pc,
    input  logic resolve_taken,
    input  pc_t  resolve_target,
    input  logic resolve_pred_taken,
    input  pc_t  resolve_pred_target,

    // DUT responses
    input  logic pred_taken,
    input  pc_t  pred_target,
    input  logic btb_hit,
    input  pc_t  next_fetch_pc,
    input  logic mispredict,
    input  pc_t  redirect_pc,

    // test sequencing from the testbench top
    input  int   test_id,
    input  logic test_done,

    output int   check_count,
    output int   error_count
);

    logic [1:0]  model_cnt   [256];    // one counter per pc[9:2]
    logic        model_valid [64];     // btb entry per pc[7:2]
    logic [23:0] model_tag   [64];
    pc_t         model_tgt   [64];

    logic exp_mispredict;
    pc_t  exp_redirect;
    int   test_checks;
    int   test_errors;

    function automatic string test_name(input int id);
        case (id)
            0: return "reset_state";
            1: return "training";
            2: return "hysteresis";
            3: return "mispredict";
            4: return "aliasing";
            5: return "random_mix";
            default: return "unknown";
        endcase
    endfunction

    // saturating step: up on taken, down on not taken
    function automatic logic [1:0] step_count(input logic [1:0] c, input logic taken);
        if (taken) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    task automatic check_value(input string what, input pc_t expected, input pc_t actual);
        check_count++;
        test_checks++;
        if (expected !== actual) begin
            error_count++;
            test_errors++;
            $display("[ERROR] %s: %s expected %h actual %h",
                     test_name(test_id), what, expected, actual);
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 256; i++) begin
            model_cnt[i] = 2'd0;
        end
        for (int i = 0; i < 64; i++) begin
            model_valid[i] = 1'b0;
        end
        exp_mispredict = 1'b0;
        exp_redirect   = '0;
        check_count    = 0;
        error_count    = 0;
        test_checks    = 0;
        test_errors    = 0;
    endtask

    // tables still hold the contents from before this edge
    task automatic compare_lookup();
        logic [7:0] bi;
        logic [5:0] ti;
        logic       hit_exp;
        logic       taken_exp;
        pc_t        nfp_exp;
        bi        = fetch_pc[9:2];
        ti        = fetch_pc[7:2];
        hit_exp   = model_valid[ti] && (model_tag[ti] == fetch_pc[31:8]);
        taken_exp = hit_exp && model_cnt[bi][1];
        nfp_exp   = taken_exp ? model_tgt[ti] : fetch_pc + 32'd4;
        check_value("btb_hit", {31'b0, hit_exp}, {31'b0, btb_hit});
        check_value("pred_taken", {31'b0, taken_exp}, {31'b0, pred_taken});
        if (hit_exp) begin
            check_value("pred_target", model_tgt[ti], pred_target);
        end
        check_value("next_fetch_pc", nfp_exp, next_fetch_pc);
    endtask

    task automatic apply_resolve();
        pc_t actual;
        pc_t predicted;
        if (!resolve_valid) begin
            exp_mispredict = 1'b0;    // redirect_pc holds its last value
            return;
        end
        actual    = resolve_taken ? resolve_target : resolve_pc + 32'd4;
        predicted = resolve_pred_taken ? resolve_pred_target : resolve_pc + 32'd4;
        exp_mispredict = (actual != predicted);
        exp_redirect   = actual;
        model_cnt[resolve_pc[9:2]] = step_count(model_cnt[resolve_pc[9:2]], resolve_taken);
        if (resolve_taken) begin
            model_valid[resolve_pc[7:2]] = 1'b1;
            model_tag[resolve_pc[7:2]]   = resolve_pc[31:8];
            model_tgt[resolve_pc[7:2]]   = resolve_target;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            reset_model();
        end else begin
            compare_lookup();
            // registered outputs belong to the previous cycle's resolve
            check_value("mispredict", {31'b0, exp_mispredict}, {31'b0, mispredict});
            check_value("redirect_pc", exp_redirect, redirect_pc);
            apply_resolve();
            if (test_done) begin
                $display("test %0d %s: %0d checks, %0d errors, %s", test_id,
                         test_name(test_id), test_checks, test_errors,
                         (test_errors == 0) ? "ok" : "bad");
                test_checks = 0;
                test_errors = 0;
            end
        end
    end

endmodule

// ==== testbench/tb_branch_predictor.sv ====
/*
 * Testbench top for the branch predictor: clock, reset, directed and
 * random stimulus, watchdog, DUT and checker instances, final report
 */
`timescale 1ns/1ps

module tb_branch_predictor
    import bp_types_pkg::*;
();

    localparam int CLK_PERIOD_NS   = 10;
    localparam int RESET_CYCLES    = 3;
    localparam int DIRECTED_CYCLES = 120;    // upper bound over tests 1 to 5
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_NS      =
        2 * (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD_NS;

    localparam pc_t WINDOW_BASE = 32'h0000_8000;
    localparam pc_t WINDOW_MASK = 32'h0000_0ffc;    // 1024 word addresses

    logic clk;
    logic reset;
    pc_t  fetch_pc;
    logic resolve_valid;
    pc_t  resolve_pc;
    logic resolve_taken;
    pc_t  resolve_target;
    logic resolve_pred_taken;
    pc_t  resolve_pred_target;
    logic pred_taken;
    pc_t  pred_target;
    logic btb_hit;
    pc_t  next_fetch_pc;
    logic mispredict;
    pc_t  redirect_pc;

    int   seed;
    int   test_id;
    logic test_done;
    int   check_count;
    int   error_count;

    branch_predictor DUT (
        .clk                 (clk),
        .reset               (reset),
        .fetch_pc            (fetch_pc),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .pred_taken          (pred_taken),
        .pred_target         (pred_target),
        .btb_hit             (btb_hit),
        .next_fetch_pc       (next_fetch_pc),
        .mispredict          (mispredict),
        .redirect_pc         (redirect_pc)
    );

    bp_checker u_checker (
        .clk                 (clk),
        .reset               (reset),
        .fetch_pc            (fetch_pc),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .pred_taken          (pred_taken),
        .pred_target         (pred_target),
        .btb_hit             (btb_hit),
        .next_fetch_pc       (next_fetch_pc),
        .mispredict          (mispredict),
        .redirect_pc         (redirect_pc),
        .test_id             (test_id),
        .test_done           (test_done),
        .check_count         (check_count),
        .error_count         (error_count)
    );

    always #(CLK_PERIOD_NS / 2) clk = ~clk;

    // one cycle of inputs, changed on the falling edge
    task automatic apply_inputs(input pc_t fpc, input logic rv, input pc_t rpc,
                                input logic rt, input pc_t rtgt,
                                input logic rpt, input pc_t rptgt);
        @(negedge clk);
        test_done           = 1'b0;
        fetch_pc            = fpc;
        resolve_valid       = rv;
        resolve_pc          = rpc;
        resolve_taken       = rt;
        resolve_target      = rtgt;
        resolve_pred_taken  = rpt;
        resolve_pred_target = rptgt;
    endtask

    task automatic lookup_only(input pc_t fpc);
        apply_inputs(fpc, 1'b0, '0, 1'b0, '0, 1'b0, '0);
    endtask

    task automatic resolve_branch(input pc_t rpc, input logic rt, input pc_t rtgt,
                                  input logic rpt, input pc_t rptgt);
        apply_inputs(32'h0000_0100, 1'b1, rpc, rt, rtgt, rpt, rptgt);
    endtask

    // idle cycle so the last mispredict is checked, then the next test id
    task automatic close_test();
        @(negedge clk);
        resolve_valid = 1'b0;
        test_done     = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
        test_id++;
    endtask

    task automatic random_pc(output pc_t pc);
        pc = WINDOW_BASE | ($random(seed) & WINDOW_MASK);
    endtask

    initial begin
        pc_t fpc;
        pc_t rpc;
        pc_t tgt;
        pc_t ptgt;
        int  r;
        clk                 = 1'b0;
        reset               = 1'b1;
        fetch_pc            = '0;
        resolve_valid       = 1'b0;
        resolve_pc          = '0;
        resolve_taken       = 1'b0;
        resolve_target      = '0;
        resolve_pred_taken  = 1'b0;
        resolve_pred_target = '0;
        test_id             = 0;
        test_done           = 1'b0;
        seed                = 11884;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // reset state
        repeat (20) begin
            random_pc(fpc);
            lookup_only(fpc);
        end
        close_test();

        // training, two taken resolves reach weak_t
        resolve_branch(32'h0000_1040, 1'b1, 32'h0000_2200, 1'b0, '0);
        resolve_branch(32'h0000_1040, 1'b1, 32'h0000_2200, 1'b0, '0);
        lookup_only(32'h0000_1040);
        close_test();

        // hysteresis and saturation
        repeat (4) resolve_branch(32'h0000_1040, 1'b1, 32'h0000_2200, 1'b1, 32'h0000_2200);
        resolve_branch(32'h0000_1040, 1'b0, '0, 1'b1, 32'h0000_2200);
        lookup_only(32'h0000_1040);
        resolve_branch(32'h0000_1040, 1'b0, '0, 1'b1, 32'h0000_2200);
        lookup_only(32'h0000_1040);
        close_test();

        // misprediction cases, some back to back
        resolve_branch(32'h0000_3000, 1'b0, '0, 1'b0, '0);
        lookup_only(32'h0000_3000);
        resolve_branch(32'h0000_3000, 1'b1, 32'h0000_3400, 1'b1, 32'h0000_3400);
        resolve_branch(32'h0000_3000, 1'b1, 32'h0000_3400, 1'b1, 32'h0000_3800);
        resolve_branch(32'h0000_3000, 1'b0, '0, 1'b1, 32'h0000_3400);
        resolve_branch(32'h0000_3000, 1'b1, 32'h0000_3400, 1'b0, '0);
        lookup_only(32'h0000_3000);
        lookup_only(32'h0000_3000);
        resolve_branch(32'h0000_3000, 1'b1, 32'h0000_3004, 1'b0, '0);    // taken to fall-through
        lookup_only(32'h0000_3000);
        close_test();

        // aliasing, same pc[9:2] and pc[7:2], different tag
        resolve_branch(32'h0000_0124, 1'b1, 32'h0000_0600, 1'b0, '0);
        resolve_branch(32'h0000_0124, 1'b1, 32'h0000_0600, 1'b0, '0);
        lookup_only(32'h0000_0124);
        lookup_only(32'h0000_0524);
        resolve_branch(32'h0000_0524, 1'b1, 32'h0000_0900, 1'b0, '0);
        lookup_only(32'h0000_0524);
        lookup_only(32'h0000_0124);
        close_test();

        // random mix inside the address window
        repeat (RANDOM_CYCLES) begin
            random_pc(fpc);
            random_pc(rpc);
            random_pc(tgt);
            random_pc(ptgt);
            r = $random(seed);
            if (r[1]) begin
                rpc = fpc;    // lookup and update of one entry in one cycle
            end
            if (r[2]) begin
                ptgt = tgt;
            end
            apply_inputs(fpc, r[0], rpc, r[3], tgt, r[4], ptgt);
        end
        close_test();

        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== files.f ====
hw/bp_config_pkg.sv
hw/bp_types_pkg.sv
hw/bht.sv
hw/btb.sv
hw/mispredict_check.sv
hw/branch_predictor.sv
testbench/bp_checker.sv
testbench/tb_branch_predictor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the branch predictor testbench with Verilator.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_branch_predictor

verilator --binary --timing --timescale 1ns/1ps \
    -f files.f --top-module "$TOP" -o sim_"$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile failed with status $status"
    exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
fi

echo "result: fail, pass message not found in $LOG"
exit 1
